// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    localparam int NUM_WAYS = 8;
    localparam int NUM_SETS = 64;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;  // byte offset inside a 64-bit line
    localparam int TAG_W    = 23; // address 31:9

    typedef logic [31:0]         addr_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [63:0]         line_t; // also the bus data word
    typedef logic [31:0]         inst_t;
    typedef logic [NUM_WAYS-1:0] way_mask_t;

    typedef enum logic [1:0] {
        EXC_NONE         = 2'd0,
        EXC_MISALIGN     = 2'd1,
        EXC_ACCESS_FAULT = 2'd2
    } exc_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_LOOKUP = 3'd1,
        ST_ADDR   = 3'd2,
        ST_DATA   = 3'd3,
        ST_FILL   = 3'd4,
        ST_DONE   = 3'd5
    } fetch_state_e;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        inst_t inst;
        exc_e  exc;
    } fetch_rsp_t;

    typedef struct packed {
        logic  arvalid;
        addr_t araddr;
    } axi_ar_t;

    typedef struct packed {
        logic  rvalid;
        resp_e rresp;
        line_t rdata;
    } axi_r_t;

endpackage

// ==== source/tag_store.sv ====
`timescale 1ns/100ps

module tag_store (
    input  logic                clk,
    input  logic                rst,
    input  fetch_pkg::index_t   index,
    input  fetch_pkg::tag_t     tag,
    input  logic                fill,
    input  logic                fence_i,
    output logic                hit,
    output fetch_pkg::way_mask_t hit_ways,
    output fetch_pkg::way_mask_t victim_ways
);

    fetch_pkg::way_mask_t valid [fetch_pkg::NUM_SETS];
    fetch_pkg::tag_t      tags  [fetch_pkg::NUM_WAYS][fetch_pkg::NUM_SETS];

    fetch_pkg::way_mask_t set_valid;

    assign set_valid = valid[index];

    // parallel compare of all ways
    always_comb begin
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            hit_ways[w] = set_valid[w] && (tags[w][index] == tag);
        end
    end

    assign hit = |hit_ways;

    // lowest invalid way, way 0 once the set is full
    always_comb begin
        logic found;
        found       = 1'b0;
        victim_ways = '0;
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (!found && !set_valid[w]) begin
                victim_ways[w] = 1'b1;
                found          = 1'b1;
            end
        end
        if (!found) begin
            victim_ways[0] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < fetch_pkg::NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill) begin // fill beats a same-cycle fence
            valid[index] <= set_valid | victim_ways;
        end else if (fence_i) begin
            for (int s = 0; s < fetch_pkg::NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (fill && victim_ways[w]) begin
                tags[w][index] <= tag;
            end
        end
    end

endmodule

// ==== source/line_store.sv ====
`timescale 1ns/100ps

module line_store (
    input  logic                 clk,
    input  fetch_pkg::index_t    index,
    input  logic                 fill,
    input  fetch_pkg::way_mask_t victim_ways,
    input  fetch_pkg::line_t     fill_line,
    input  fetch_pkg::way_mask_t hit_ways,
    output fetch_pkg::line_t     line
);

    fetch_pkg::line_t lines [fetch_pkg::NUM_WAYS][fetch_pkg::NUM_SETS];
    fetch_pkg::line_t rd_q  [fetch_pkg::NUM_WAYS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (fill && victim_ways[w]) begin
                lines[w][index] <= fill_line;
                rd_q[w]         <= fill_line; // new line visible right after fill
            end else begin
                rd_q[w] <= lines[w][index];
            end
        end
    end

    // at most one way hits
    always_comb begin
        line = '0;
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (hit_ways[w]) begin
                line = line | rd_q[w];
            end
        end
    end

endmodule

// ==== source/fetch_control.sv ====
`timescale 1ns/100ps

module fetch_control (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::fetch_req_t  req,
    output logic                   req_ready,
    input  logic                   fence_i,
    output fetch_pkg::fetch_rsp_t  rsp,
    input  logic                   rsp_ready,
    input  logic                   hit,
    input  fetch_pkg::line_t       cache_line,
    output logic                   fill,
    output fetch_pkg::line_t       fill_line,
    output fetch_pkg::axi_ar_t     ar,
    input  logic                   arready,
    input  fetch_pkg::axi_r_t      r,
    output logic                   rready
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::exc_e         exc_q;
    fetch_pkg::inst_t        inst_q;
    fetch_pkg::inst_t        lookup_inst;
    fetch_pkg::line_t        src_line;

    logic misaligned;
    logic cacheable;
    logic bus_err;
    logic start;

    assign misaligned = req.valid && (req.pc[1:0] != 2'b00);
    assign cacheable  = req.pc[31];
    assign start      = req.valid && !misaligned && !fence_i;
    assign bus_err    = (r.rresp != fetch_pkg::RESP_OKAY) &&
                        (r.rresp != fetch_pkg::RESP_EXOKAY);

    assign req_ready = (state == fetch_pkg::ST_IDLE);
    assign fill      = (state == fetch_pkg::ST_FILL);
    assign rready    = (state == fetch_pkg::ST_DATA);

    assign ar.arvalid = (state == fetch_pkg::ST_ADDR);
    assign ar.araddr  = cacheable ? {req.pc[31:3], 3'b000} : req.pc;

    // uncached data never goes through the arrays
    assign src_line    = cacheable ? cache_line : fill_line;
    assign lookup_inst = req.pc[2] ? src_line[63:32] : src_line[31:0];

    // misalign answers at once from idle
    always_comb begin
        rsp.valid = 1'b0;
        rsp.inst  = '0;
        rsp.exc   = fetch_pkg::EXC_NONE;
        if (state == fetch_pkg::ST_DONE) begin
            rsp.valid = 1'b1;
            rsp.inst  = inst_q;
            rsp.exc   = exc_q;
        end else if (state == fetch_pkg::ST_IDLE && misaligned) begin
            rsp.valid = 1'b1;
            rsp.exc   = fetch_pkg::EXC_MISALIGN;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fetch_pkg::ST_IDLE;
            exc_q <= fetch_pkg::EXC_NONE;
        end else begin
            case (state)
                fetch_pkg::ST_IDLE: begin
                    if (start) begin
                        state <= (cacheable && hit) ? fetch_pkg::ST_LOOKUP
                                                    : fetch_pkg::ST_ADDR;
                    end
                end
                fetch_pkg::ST_ADDR: begin
                    if (arready) begin
                        state <= fetch_pkg::ST_DATA;
                    end
                end
                fetch_pkg::ST_DATA: begin
                    if (r.rvalid) begin
                        if (bus_err) begin
                            state <= fetch_pkg::ST_DONE;
                            exc_q <= fetch_pkg::EXC_ACCESS_FAULT;
                        end else if (cacheable) begin
                            state <= fetch_pkg::ST_FILL;
                        end else begin
                            state <= fetch_pkg::ST_LOOKUP;
                        end
                    end
                end
                fetch_pkg::ST_FILL: begin
                    state <= fetch_pkg::ST_LOOKUP;
                end
                fetch_pkg::ST_LOOKUP: begin
                    state <= fetch_pkg::ST_DONE;
                    exc_q <= fetch_pkg::EXC_NONE;
                end
                fetch_pkg::ST_DONE: begin
                    if (rsp_ready) begin
                        state <= fetch_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= fetch_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_pkg::ST_DATA && r.rvalid) begin
            fill_line <= r.rdata;
            inst_q    <= '0; // stays zero on access fault
        end
        if (state == fetch_pkg::ST_LOOKUP) begin
            inst_q <= lookup_inst;
        end
    end

endmodule

// ==== source/fetch_cache.sv ====
`timescale 1ns/100ps

module fetch_cache (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::fetch_req_t req,
    output logic                  req_ready,
    input  logic                  fence_i,
    output fetch_pkg::fetch_rsp_t rsp,
    input  logic                  rsp_ready,
    output fetch_pkg::axi_ar_t    ar,
    input  logic                  arready,
    input  fetch_pkg::axi_r_t     r,
    output logic                  rready
);

    fetch_pkg::index_t    index;
    fetch_pkg::tag_t      tag;
    fetch_pkg::way_mask_t hit_ways;
    fetch_pkg::way_mask_t victim_ways;
    fetch_pkg::line_t     cache_line;
    fetch_pkg::line_t     fill_line;

    logic hit;
    logic fill;

    assign index = req.pc[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];
    assign tag   = req.pc[fetch_pkg::OFFSET_W + fetch_pkg::INDEX_W +: fetch_pkg::TAG_W];

    tag_store u_tag_store (
        .clk         (clk),
        .rst         (rst),
        .index       (index),
        .tag         (tag),
        .fill        (fill),
        .fence_i     (fence_i),
        .hit         (hit),
        .hit_ways    (hit_ways),
        .victim_ways (victim_ways)
    );

    line_store u_line_store (
        .clk         (clk),
        .index       (index),
        .fill        (fill),
        .victim_ways (victim_ways),
        .fill_line   (fill_line),
        .hit_ways    (hit_ways),
        .line        (cache_line)
    );

    fetch_control u_fetch_control (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_ready  (req_ready),
        .fence_i    (fence_i),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready),
        .hit        (hit),
        .cache_line (cache_line),
        .fill       (fill),
        .fill_line  (fill_line),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .rready     (rready)
    );

endmodule

// ==== testbench/fetch_cache_assertions.sv ====
`timescale 1ns/100ps

module fetch_cache_assertions (
    input logic                  clk,
    input logic                  rst,
    input fetch_pkg::fetch_req_t req,
    input logic                  req_ready,
    input fetch_pkg::fetch_rsp_t rsp,
    input logic                  rsp_ready,
    input fetch_pkg::axi_ar_t    ar,
    input logic                  arready
);

    int fail_count = 0; // polled by the testbench

    ar_held: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid && !arready |=> $stable(ar))
        else begin
            $error("ar changed before arready");
            fail_count++;
        end

    rsp_held: assert property (@(posedge clk) disable iff (rst)
        rsp.valid && !rsp_ready |=> $stable(rsp))
        else begin
            $error("rsp changed before rsp_ready");
            fail_count++;
        end

    ar_quiet: assert property (@(posedge clk) disable iff (rst)
        $rose(ar.arvalid) |-> !rsp.valid)
        else begin
            $error("arvalid rose during a response");
            fail_count++;
        end

    idle_no_rsp: assert property (@(posedge clk) disable iff (rst)
        (req.pc[1:0] == 2'b00) |-> !(req_ready && rsp.valid))
        else begin
            $error("response in idle for an aligned pc");
            fail_count++;
        end

endmodule

bind fetch_control fetch_cache_assertions u_assertions (.*);

// ==== testbench/fetch_cache_tb.sv ====
`timescale 1ns/100ps

module fetch_cache_tb;

    localparam int TIMEOUT = 100; // cycles per wait

    logic clk;
    logic rst;
    logic fence_i;
    logic rsp_ready;
    logic arready;
    logic req_ready;
    logic rready;
    fetch_pkg::fetch_req_t req;
    fetch_pkg::fetch_rsp_t rsp;
    fetch_pkg::axi_ar_t    ar;
    fetch_pkg::axi_r_t     r;
    fetch_pkg::addr_t      exp_araddr;
    fetch_pkg::addr_t      line_addr;

    int ar_count  = 0;
    int mem_phase = 0;
    int mem_delay;
    int mem_wait;

    fetch_cache DUT (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_ready (req_ready),
        .fence_i   (fence_i),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready)
    );

    always #2 clk = ~clk;

    // memory word at word address a is a xor constant
    function automatic fetch_pkg::inst_t mem_word(fetch_pkg::addr_t byte_addr);
        return {2'b00, byte_addr[31:2]} ^ 32'h1357_9bdf;
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_inst(fetch_pkg::inst_t got, fetch_pkg::inst_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: rsp.inst = %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_exc(fetch_pkg::exc_e got, fetch_pkg::exc_e exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: rsp.exc = %s, expected %s",
                                $time, got.name(), exp.name()));
        end
    endtask

    task automatic check_addr(fetch_pkg::addr_t got, fetch_pkg::addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: ar.araddr = %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_latency(int got, int exp);
        if (got != exp) begin
            abort_run($sformatf("** Error at %0t: hit latency = %0d, expected %0d",
                                $time, got, exp));
        end
    endtask

    // AXI read slave with random arready and rvalid delays
    always @(negedge clk) begin
        if (mem_phase == 4) begin
            r         = '0;
            mem_phase = 0;
        end
        if (mem_phase == 2) begin // AR handshake took place at the last edge
            arready   = 1'b0;
            ar_count++;
            mem_delay = $urandom_range(0, 3);
            mem_wait  = 0;
            mem_phase = 3;
        end
        if (mem_phase == 3) begin
            if (mem_delay > 0) begin
                mem_delay--;
            end else if (rready) begin
                r.rvalid  = 1'b1;
                r.rdata   = {mem_word(line_addr + 32'd4), mem_word(line_addr)};
                // error window sits in both halves of the map
                r.rresp   = (line_addr[30:28] == 3'h6) ? fetch_pkg::RESP_SLVERR
                                                       : fetch_pkg::RESP_OKAY;
                mem_phase = 4;
            end else begin
                mem_wait++;
                if (mem_wait > TIMEOUT) begin
                    abort_run("rready never rose after the AR handshake");
                end
            end
        end
        if (mem_phase == 0 && ar.arvalid) begin
            mem_delay = $urandom_range(0, 3);
            mem_phase = 1;
        end
        if (mem_phase == 1) begin
            check_flag("rready", rready, 1'b0);
            if (mem_delay > 0) begin
                mem_delay--;
            end else begin
                check_addr(ar.araddr, exp_araddr);
                line_addr = {ar.araddr[31:3], 3'b000};
                arready   = 1'b1;
                mem_phase = 2;
            end
        end
    end

    always @(negedge clk) begin
        if (DUT.u_fetch_control.u_assertions.fail_count != 0) begin
            abort_run("a bound assertion failed");
        end
    end

    task automatic do_fetch(fetch_pkg::addr_t pc, logic exp_read, fetch_pkg::exc_e exp_exc);
        int reads_before;
        int cycles;
        check_flag("req_ready", req_ready, 1'b1);
        reads_before = ar_count;
        exp_araddr   = pc[31] ? {pc[31:3], 3'b000} : pc;
        req.valid    = 1'b1;
        req.pc       = pc;
        cycles       = 0;
        #1;
        while (!rsp.valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("no response for pc %h", pc));
            end
        end
        check_exc(rsp.exc, exp_exc);
        check_inst(rsp.inst, (exp_exc == fetch_pkg::EXC_NONE) ? mem_word(pc) : '0);
        check_flag("req_ready", req_ready, exp_exc == fetch_pkg::EXC_MISALIGN);
        if (exp_exc == fetch_pkg::EXC_NONE && !exp_read) begin
            check_latency(cycles, 2);
        end
        repeat ($urandom_range(0, 3)) @(negedge clk);
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        req.valid = 1'b0;
        check_flag("bus read", ar_count != reads_before, exp_read);
    endtask

    task automatic do_fence();
        fence_i = 1'b1;
        @(negedge clk);
        fence_i = 1'b0;
    endtask

    initial begin
        int               fd;
        int               n;
        int               flag;
        int               exc;
        byte              op;
        string            text;
        fetch_pkg::addr_t pc;
        void'($urandom(32'hb142));
        clk       = 1'b0;
        rst       = 1'b1;
        fence_i   = 1'b0;
        rsp_ready = 1'b0;
        arready   = 1'b0;
        req       = '0;
        r         = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd  = $fopen("testbench/fetch_cache_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            n = $sscanf(text, "%c %h %d %d", op, pc, flag, exc);
            if (n != 4) begin
                abort_run({"unreadable stimulus line: ", text});
            end
            if (op == "I") begin
                do_fence();
            end else begin
                do_fetch(pc, flag[0], fetch_pkg::exc_e'(exc[1:0]));
            end
        end
        $fclose(fd);
        repeat (4) @(negedge clk);
        if (DUT.u_fetch_control.u_assertions.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("a bound assertion failed");
        end
    end

endmodule

// ==== fetch_cache.f ====
source/fetch_pkg.sv
source/tag_store.sv
source/line_store.sv
source/fetch_control.sv
source/fetch_cache.sv
testbench/fetch_cache_assertions.sv
testbench/fetch_cache_tb.sv

// ==== testbench/fetch_cache_stimulus.txt ====
# op pc expect_bus_read expect_exc
# op F fetch, I fence (pc unused); exc 0 none, 1 misalign, 2 access fault
F 80000100 1 0
F 80000104 0 0
F 0000100c 1 0
F 0000100c 1 0
F 80000102 0 1
F 00000203 0 1
I 00000000 0 0
F 80000100 1 0
F e0000040 1 2
F e0000040 1 2
F 60000008 1 2
F 80000000 1 0
F 80000204 1 0
F 80000400 1 0
F 80000604 1 0
F 80000800 1 0
F 80000a04 1 0
F 80000c00 1 0
F 80000e04 1 0
F 80001000 1 0
F 80000200 0 0
F 80001004 0 0
F 80000000 1 0
